//--- include/tm_params.svh
// Array sizing; TM_NUM_TILES must fit in TM_ID_W bits and the payload must hold a config write
`ifndef TM_PARAMS_SVH
`define TM_PARAMS_SVH

// Tile array
`define TM_NUM_TILES 4
`define TM_ID_W 2

// Flit layout
`define TM_FLIT_W 32
`define TM_PAYLOAD_W 24

// Config register port
`define TM_CFG_ADDR_W 4
`define TM_CFG_DATA_W 16

// Skid stages per direction between neighbouring tiles, 0 gives a plain wire
`define TM_REPEATER_DEPTH 1

`endif

//--- rtl/tm_cfg_if.sv
// Router to config block link; net_v/net_ready follow the same handshake as the tile links
`timescale 1ns/100ps
`include "tm_params.svh"

interface tm_cfg_if;

   logic                      net_v;
   logic [`TM_CFG_ADDR_W-1:0] net_addr;
   logic [`TM_CFG_DATA_W-1:0] net_data;
   logic                      net_ready;
   logic                      eject_en;
   logic [`TM_CFG_DATA_W-1:0] eject_tag;

   modport router
   (
      output net_v, net_addr, net_data,
      input  net_ready, eject_en, eject_tag
   );

   modport cfg
   (
      input  net_v, net_addr, net_data,
      output net_ready, eject_en, eject_tag
   );

endinterface

//--- rtl/tm_link_repeater.sv
// Adds depth cycles per direction at full rate; depth 0 is a plain wire with no registers
`timescale 1ns/100ps
`include "tm_params.svh"

module tm_link_repeater
   import tm_noc_pkg::*;
#(
   parameter int depth = 1
)
(
   input  logic     clk_i,
   input  logic     rst_i,

   input  logic     a_v_i,
   input  tm_flit_s a_flit_i,
   output logic     a_ready_o,
   output logic     a_v_o,
   output tm_flit_s a_flit_o,
   input  logic     a_ready_i,

   input  logic     b_v_i,
   input  tm_flit_s b_flit_i,
   output logic     b_ready_o,
   output logic     b_v_o,
   output tm_flit_s b_flit_o,
   input  logic     b_ready_i
);

   // Index 0 runs a to b, index 1 runs b to a
   logic     v     [2][depth+1];
   tm_flit_s flit  [2][depth+1];
   logic     ready [2][depth+1];

   assign v[0][0]        = a_v_i;
   assign flit[0][0]     = a_flit_i;
   assign a_ready_o      = ready[0][0];
   assign b_v_o          = v[0][depth];
   assign b_flit_o       = flit[0][depth];
   assign ready[0][depth] = b_ready_i;

   assign v[1][0]        = b_v_i;
   assign flit[1][0]     = b_flit_i;
   assign b_ready_o      = ready[1][0];
   assign a_v_o          = v[1][depth];
   assign a_flit_o       = flit[1][depth];
   assign ready[1][depth] = a_ready_i;

   for (genvar d = 0; d < 2; d++)
   begin : g_dir
      for (genvar s = 0; s < depth; s++)
      begin : g_stage
         logic     main_v;
         logic     skid_v;
         logic     in_take;
         logic     main_free;
         tm_flit_s main_d;
         tm_flit_s skid_d;

         // Ready comes straight from a flop
         assign ready[d][s] = ~skid_v;
         assign in_take     = v[d][s] & ~skid_v;
         assign main_free   = ~main_v | ready[d][s+1];

         always_ff @(posedge clk_i)
         begin
            if (rst_i)
            begin
               main_v <= 1'b0;
               skid_v <= 1'b0;
            end
            else if (main_free)
            begin
               main_v <= skid_v | v[d][s];
               skid_v <= 1'b0;
            end
            else if (in_take)
               skid_v <= 1'b1;
         end

         always_ff @(posedge clk_i)
         begin
            if (main_free)
               main_d <= skid_v ? skid_d : flit[d][s];
            else if (in_take)
               skid_d <= flit[d][s];
         end

         assign v[d][s+1]    = main_v;
         assign flit[d][s+1] = main_d;
      end
   end

endmodule

//--- rtl/tm_noc_pkg.sv
// Flit layout for the east-west network; the fields below must add up to TM_FLIT_W
`include "tm_params.svh"

package tm_noc_pkg;

   typedef enum logic
   {
      e_msg_data = 1'b0,
      e_msg_cfg  = 1'b1
   } tm_msg_e;

   // Config write as carried in the payload
   typedef struct packed
   {
      logic [`TM_CFG_ADDR_W-1:0]                              addr;
      logic [`TM_PAYLOAD_W-`TM_CFG_ADDR_W-`TM_CFG_DATA_W-1:0] rsvd;
      logic [`TM_CFG_DATA_W-1:0]                              data;
   } tm_cfg_wr_s;

   // Same payload bits, read by message kind
   typedef union packed
   {
      logic [`TM_PAYLOAD_W-1:0] data;
      tm_cfg_wr_s               cfg;
   } tm_payload_u;

   typedef struct packed
   {
      tm_msg_e                                         msg;
      logic [`TM_ID_W-1:0]                             dst;
      logic [`TM_ID_W-1:0]                             src;
      logic [`TM_FLIT_W-1-2*`TM_ID_W-`TM_PAYLOAD_W-1:0] rsvd;
      tm_payload_u                                     payload;
   } tm_flit_s;

   // Router ports, also used as array indices inside the router
   typedef enum logic [1:0]
   {
      e_port_w = 2'd0,
      e_port_e = 2'd1,
      e_port_l = 2'd2
   } tm_port_e;

endpackage

//--- rtl/tm_tile.sv
// One network tile; tile_id must be unique in the array and match the flit dst encoding
`timescale 1ns/100ps
`include "tm_params.svh"

module tm_tile
   import tm_noc_pkg::*;
#(
   parameter int tile_id = 0
)
(
   input  logic                      clk_i,
   input  logic                      rst_i,

   input  logic                      w_v_i,
   input  tm_flit_s                  w_flit_i,
   output logic                      w_ready_o,
   output logic                      w_v_o,
   output tm_flit_s                  w_flit_o,
   input  logic                      w_ready_i,

   input  logic                      e_v_i,
   input  tm_flit_s                  e_flit_i,
   output logic                      e_ready_o,
   output logic                      e_v_o,
   output tm_flit_s                  e_flit_o,
   input  logic                      e_ready_i,

   input  logic                      inj_v_i,
   input  tm_flit_s                  inj_flit_i,
   output logic                      inj_ready_o,
   output logic                      ej_v_o,
   output tm_flit_s                  ej_flit_o,
   output logic [`TM_CFG_DATA_W-1:0] ej_tag_o,
   input  logic                      ej_ready_i,

   input  logic                      cfg_w_v_i,
   input  logic [`TM_CFG_ADDR_W-1:0] cfg_addr_i,
   input  logic [`TM_CFG_DATA_W-1:0] cfg_data_i
);

   tm_cfg_if cfg_bus ();

   tm_tile_router #(
      .tile_id (tile_id)
   ) router (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .w_v_i       (w_v_i),
      .w_flit_i    (w_flit_i),
      .w_ready_o   (w_ready_o),
      .w_v_o       (w_v_o),
      .w_flit_o    (w_flit_o),
      .w_ready_i   (w_ready_i),
      .e_v_i       (e_v_i),
      .e_flit_i    (e_flit_i),
      .e_ready_o   (e_ready_o),
      .e_v_o       (e_v_o),
      .e_flit_o    (e_flit_o),
      .e_ready_i   (e_ready_i),
      .inj_v_i     (inj_v_i),
      .inj_flit_i  (inj_flit_i),
      .inj_ready_o (inj_ready_o),
      .ej_v_o      (ej_v_o),
      .ej_flit_o   (ej_flit_o),
      .ej_tag_o    (ej_tag_o),
      .ej_ready_i  (ej_ready_i),
      .bus         (cfg_bus.router)
   );

   tm_tile_cfg cfg (
      .clk_i      (clk_i),
      .rst_i      (rst_i),
      .cfg_w_v_i  (cfg_w_v_i),
      .cfg_addr_i (cfg_addr_i),
      .cfg_data_i (cfg_data_i),
      .bus        (cfg_bus.cfg)
   );

endmodule

//--- rtl/tm_tile_cfg.sv
// Local writes win over network writes in the same cycle; writes to unmapped addresses are dropped
`timescale 1ns/100ps
`include "tm_params.svh"

module tm_tile_cfg
   import tm_tile_pkg::*;
(
   input  logic                      clk_i,
   input  logic                      rst_i,

   input  logic                      cfg_w_v_i,
   input  logic [`TM_CFG_ADDR_W-1:0] cfg_addr_i,
   input  logic [`TM_CFG_DATA_W-1:0] cfg_data_i,

   tm_cfg_if.cfg                     bus
);

   tm_ctrl_s                  ctrl_q;
   logic [`TM_CFG_DATA_W-1:0] tag_q;
   logic                      wr_v;
   logic [`TM_CFG_ADDR_W-1:0] wr_addr;
   logic [`TM_CFG_DATA_W-1:0] wr_data;

   // Network side stalls while the local port writes
   assign bus.net_ready = ~cfg_w_v_i;

   assign wr_v    = cfg_w_v_i | bus.net_v;
   assign wr_addr = cfg_w_v_i ? cfg_addr_i : bus.net_addr;
   assign wr_data = cfg_w_v_i ? cfg_data_i : bus.net_data;

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         ctrl_q.rsvd     <= '0;
         ctrl_q.eject_en <= 1'b1;
         tag_q           <= '0;
      end
      else if (wr_v)
      begin
         case (wr_addr)
            e_cfg_ctrl:
            begin
               ctrl_q.rsvd     <= '0;
               ctrl_q.eject_en <= wr_data[0];
            end
            e_cfg_tag:
               tag_q <= wr_data;
            default:
               ;
         endcase
      end
   end

   assign bus.eject_en  = ctrl_q.eject_en;
   assign bus.eject_tag = tag_q;

endmodule

//--- rtl/tm_tile_mesh.sv
// Linear array of TM_NUM_TILES tiles; edge links are tied off, so flits must target ids inside the array
`timescale 1ns/100ps
`include "tm_params.svh"

module tm_tile_mesh
   import tm_noc_pkg::*;
(
   input  logic                                         clk_i,
   input  logic                                         rst_i,

   input  logic [`TM_NUM_TILES-1:0]                     inj_v_i,
   input  logic [`TM_NUM_TILES-1:0][`TM_FLIT_W-1:0]     inj_flit_i,
   output logic [`TM_NUM_TILES-1:0]                     inj_ready_o,

   output logic [`TM_NUM_TILES-1:0]                     ej_v_o,
   output logic [`TM_NUM_TILES-1:0][`TM_FLIT_W-1:0]     ej_flit_o,
   output logic [`TM_NUM_TILES-1:0][`TM_CFG_DATA_W-1:0] ej_tag_o,
   input  logic [`TM_NUM_TILES-1:0]                     ej_ready_i,

   input  logic [`TM_NUM_TILES-1:0]                     cfg_w_v_i,
   input  logic [`TM_NUM_TILES-1:0][`TM_CFG_ADDR_W-1:0] cfg_addr_i,
   input  logic [`TM_NUM_TILES-1:0][`TM_CFG_DATA_W-1:0] cfg_data_i
);

   localparam int n = `TM_NUM_TILES;

   // Link stitching, named from each tile's point of view
   logic     w_v_i     [n];
   tm_flit_s w_flit_i  [n];
   logic     w_ready_o [n];
   logic     w_v_o     [n];
   tm_flit_s w_flit_o  [n];
   logic     w_ready_i [n];
   logic     e_v_i     [n];
   tm_flit_s e_flit_i  [n];
   logic     e_ready_o [n];
   logic     e_v_o     [n];
   tm_flit_s e_flit_o  [n];
   logic     e_ready_i [n];

   // Array edges
   assign w_v_i[0]       = 1'b0;
   assign w_flit_i[0]    = '0;
   assign w_ready_i[0]   = 1'b0;
   assign e_v_i[n-1]     = 1'b0;
   assign e_flit_i[n-1]  = '0;
   assign e_ready_i[n-1] = 1'b0;

   for (genvar i = 0; i < n - 1; i++)
   begin : g_link
      tm_link_repeater #(
         .depth (`TM_REPEATER_DEPTH)
      ) repeater (
         .clk_i     (clk_i),
         .rst_i     (rst_i),
         .a_v_i     (e_v_o[i]),
         .a_flit_i  (e_flit_o[i]),
         .a_ready_o (e_ready_i[i]),
         .a_v_o     (e_v_i[i]),
         .a_flit_o  (e_flit_i[i]),
         .a_ready_i (e_ready_o[i]),
         .b_v_i     (w_v_o[i+1]),
         .b_flit_i  (w_flit_o[i+1]),
         .b_ready_o (w_ready_i[i+1]),
         .b_v_o     (w_v_i[i+1]),
         .b_flit_o  (w_flit_i[i+1]),
         .b_ready_i (w_ready_o[i+1])
      );
   end

   for (genvar i = 0; i < n; i++)
   begin : g_tile
      tm_tile #(
         .tile_id (i)
      ) tile (
         .clk_i       (clk_i),
         .rst_i       (rst_i),
         .w_v_i       (w_v_i[i]),
         .w_flit_i    (w_flit_i[i]),
         .w_ready_o   (w_ready_o[i]),
         .w_v_o       (w_v_o[i]),
         .w_flit_o    (w_flit_o[i]),
         .w_ready_i   (w_ready_i[i]),
         .e_v_i       (e_v_i[i]),
         .e_flit_i    (e_flit_i[i]),
         .e_ready_o   (e_ready_o[i]),
         .e_v_o       (e_v_o[i]),
         .e_flit_o    (e_flit_o[i]),
         .e_ready_i   (e_ready_i[i]),
         .inj_v_i     (inj_v_i[i]),
         .inj_flit_i  (inj_flit_i[i]),
         .inj_ready_o (inj_ready_o[i]),
         .ej_v_o      (ej_v_o[i]),
         .ej_flit_o   (ej_flit_o[i]),
         .ej_tag_o    (ej_tag_o[i]),
         .ej_ready_i  (ej_ready_i[i]),
         .cfg_w_v_i   (cfg_w_v_i[i]),
         .cfg_addr_i  (cfg_addr_i[i]),
         .cfg_data_i  (cfg_data_i[i])
      );
   end

endmodule

//--- rtl/tm_tile_pkg.sv
// Per-tile register map; only the control and eject tag addresses are implemented
`include "tm_params.svh"

package tm_tile_pkg;

   typedef enum logic [`TM_CFG_ADDR_W-1:0]
   {
      e_cfg_ctrl = 0,
      e_cfg_tag  = 1
   } tm_cfg_addr_e;

   // Control register, reserved bits read back as zero
   typedef struct packed
   {
      logic [`TM_CFG_DATA_W-2:0] rsvd;
      logic                      eject_en;
   } tm_ctrl_s;

endpackage

//--- rtl/tm_tile_router.sv
// One flit register per output, so a flit spends at least one cycle here; ids outside the array are not handled
`timescale 1ns/100ps
`include "tm_params.svh"

module tm_tile_router
   import tm_noc_pkg::*;
#(
   parameter int tile_id = 0
)
(
   input  logic                      clk_i,
   input  logic                      rst_i,

   input  logic                      w_v_i,
   input  tm_flit_s                  w_flit_i,
   output logic                      w_ready_o,
   output logic                      w_v_o,
   output tm_flit_s                  w_flit_o,
   input  logic                      w_ready_i,

   input  logic                      e_v_i,
   input  tm_flit_s                  e_flit_i,
   output logic                      e_ready_o,
   output logic                      e_v_o,
   output tm_flit_s                  e_flit_o,
   input  logic                      e_ready_i,

   input  logic                      inj_v_i,
   input  tm_flit_s                  inj_flit_i,
   output logic                      inj_ready_o,

   output logic                      ej_v_o,
   output tm_flit_s                  ej_flit_o,
   output logic [`TM_CFG_DATA_W-1:0] ej_tag_o,
   input  logic                      ej_ready_i,

   tm_cfg_if.router                  bus
);

   localparam logic [`TM_ID_W-1:0] my_id = `TM_ID_W'(tile_id);

   logic       in_v      [3];
   tm_flit_s   in_flit   [3];
   logic       in_ready  [3];
   tm_port_e   in_dst    [3];
   logic       out_v     [3];
   tm_flit_s   out_flit  [3];
   logic       out_drain [3];
   logic       out_load  [3];
   logic [1:0] rr_q      [3];
   logic [1:0] grant     [3];
   logic       grant_v   [3];
   logic       loc_cfg;

   assign in_v[e_port_w]    = w_v_i;
   assign in_flit[e_port_w] = w_flit_i;
   assign in_v[e_port_e]    = e_v_i;
   assign in_flit[e_port_e] = e_flit_i;
   assign in_v[e_port_l]    = inj_v_i;
   assign in_flit[e_port_l] = inj_flit_i;

   always_comb
   begin
      for (int i = 0; i < 3; i++)
      begin
         if (in_flit[i].dst == my_id)
            in_dst[i] = e_port_l;
         else if (in_flit[i].dst > my_id)
            in_dst[i] = e_port_e;
         else
            in_dst[i] = e_port_w;
      end
   end

   // Round robin, search starts just after the last winner
   always_comb
   begin
      int idx;
      for (int o = 0; o < 3; o++)
      begin
         grant_v[o] = 1'b0;
         grant[o]   = rr_q[o];
         for (int k = 1; k <= 3; k++)
         begin
            idx = (rr_q[o] + k) % 3;
            if (!grant_v[o] && in_v[idx] && in_dst[idx] == tm_port_e'(o))
            begin
               grant_v[o] = 1'b1;
               grant[o]   = 2'(idx);
            end
         end
      end
   end

   // Local slot drains to the config block or to ejection by message kind
   assign loc_cfg = out_flit[e_port_l].msg == e_msg_cfg;

   assign out_drain[e_port_w] = w_ready_i;
   assign out_drain[e_port_e] = e_ready_i;
   assign out_drain[e_port_l] = loc_cfg ? bus.net_ready : (ej_ready_i & bus.eject_en);

   always_comb
   begin
      for (int o = 0; o < 3; o++)
         out_load[o] = grant_v[o] & (~out_v[o] | out_drain[o]);
      // An idle input reads as ready
      for (int i = 0; i < 3; i++)
         in_ready[i] = !in_v[i] || (out_load[in_dst[i]] && grant[in_dst[i]] == 2'(i));
   end

   always_ff @(posedge clk_i)
   begin
      if (rst_i)
      begin
         for (int o = 0; o < 3; o++)
         begin
            out_v[o] <= 1'b0;
            rr_q[o]  <= 2'd2;
         end
      end
      else
      begin
         for (int o = 0; o < 3; o++)
         begin
            if (out_load[o])
            begin
               out_v[o] <= 1'b1;
               rr_q[o]  <= grant[o];
            end
            else if (out_drain[o])
               out_v[o] <= 1'b0;
         end
      end
   end

   always_ff @(posedge clk_i)
   begin
      for (int o = 0; o < 3; o++)
         if (out_load[o])
            out_flit[o] <= in_flit[grant[o]];
   end

   assign w_ready_o   = in_ready[e_port_w];
   assign e_ready_o   = in_ready[e_port_e];
   assign inj_ready_o = in_ready[e_port_l];

   assign w_v_o    = out_v[e_port_w];
   assign w_flit_o = out_flit[e_port_w];
   assign e_v_o    = out_v[e_port_e];
   assign e_flit_o = out_flit[e_port_e];

   // Held flit stays visible even while eject_en is low
   assign ej_v_o    = out_v[e_port_l] & ~loc_cfg;
   assign ej_flit_o = out_flit[e_port_l];
   assign ej_tag_o  = bus.eject_tag;

   assign bus.net_v    = out_v[e_port_l] & loc_cfg;
   assign bus.net_addr = out_flit[e_port_l].payload.cfg.addr;
   assign bus.net_data = out_flit[e_port_l].payload.cfg.data;

endmodule

//--- tb/tm_tile_mesh_tb.sv
// Checks a 4-tile array; network config flits only write the eject tag, control is written locally
`timescale 1ns/100ps
`include "tm_params.svh"

module tm_tile_mesh_tb
   import tm_noc_pkg::*, tm_tile_pkg::*;
;

   localparam int n_tiles     = `TM_NUM_TILES;
   localparam int wait_limit  = 200;
   localparam int drain_limit = 2000;
   localparam int n_rand      = 12;

   logic                                         clk_i = 1'b0;
   logic                                         rst_i;
   logic [`TM_NUM_TILES-1:0]                     inj_v_i;
   logic [`TM_NUM_TILES-1:0][`TM_FLIT_W-1:0]     inj_flit_i;
   logic [`TM_NUM_TILES-1:0]                     inj_ready_o;
   logic [`TM_NUM_TILES-1:0]                     ej_v_o;
   logic [`TM_NUM_TILES-1:0][`TM_FLIT_W-1:0]     ej_flit_o;
   logic [`TM_NUM_TILES-1:0][`TM_CFG_DATA_W-1:0] ej_tag_o;
   logic [`TM_NUM_TILES-1:0]                     ej_ready_i;
   logic [`TM_NUM_TILES-1:0]                     cfg_w_v_i;
   logic [`TM_NUM_TILES-1:0][`TM_CFG_ADDR_W-1:0] cfg_addr_i;
   logic [`TM_NUM_TILES-1:0][`TM_CFG_DATA_W-1:0] cfg_data_i;

   // Expected register state per tile
   logic [`TM_NUM_TILES-1:0]                     en_model;
   logic [`TM_NUM_TILES-1:0][`TM_CFG_DATA_W-1:0] tag_model;

   // Flits in flight, indexed by source then destination
   logic [`TM_FLIT_W-1:0] sb_q [n_tiles][n_tiles][$];
   logic [1:0]            rnd_dst [n_tiles][n_rand];
   logic [23:0]           rnd_pay [n_tiles][n_rand];

   int seed         = 40962;
   int err_mismatch = 0;
   int err_other    = 0;
   int checked      = 0;

   tm_tile_mesh uut (
      .clk_i       (clk_i),
      .rst_i       (rst_i),
      .inj_v_i     (inj_v_i),
      .inj_flit_i  (inj_flit_i),
      .inj_ready_o (inj_ready_o),
      .ej_v_o      (ej_v_o),
      .ej_flit_o   (ej_flit_o),
      .ej_tag_o    (ej_tag_o),
      .ej_ready_i  (ej_ready_i),
      .cfg_w_v_i   (cfg_w_v_i),
      .cfg_addr_i  (cfg_addr_i),
      .cfg_data_i  (cfg_data_i)
   );

   always #50 clk_i = ~clk_i;

   function automatic tm_flit_s make_flit(input tm_msg_e msg, input int dst, input int src,
                                          input logic [23:0] pay);
      tm_flit_s f;
      f              = '0;
      f.msg          = msg;
      f.dst          = 2'(dst);
      f.src          = 2'(src);
      f.payload.data = pay;
      return f;
   endfunction

   function automatic int queued_total();
      int total;
      total = 0;
      for (int s = 0; s < n_tiles; s++)
         for (int d = 0; d < n_tiles; d++)
            total += sb_q[s][d].size();
      return total;
   endfunction

   // Leaves valid high so the next call can follow at full rate
   task automatic inject(input int s, input tm_flit_s f);
      int n;
      @(negedge clk_i);
      inj_v_i[s]    = 1'b1;
      inj_flit_i[s] = f;
      n = 0;
      @(posedge clk_i);
      while (!inj_ready_o[s] && n < wait_limit)
      begin
         @(posedge clk_i);
         n++;
      end
      if (!inj_ready_o[s])
      begin
         err_other++;
         $display("Timeout: tile %0d never accepted flit %h", s, f);
      end
      else if (f.msg == e_msg_data)
         sb_q[s][f.dst].push_back(f);
   endtask

   task automatic release_inject(input int s);
      @(negedge clk_i);
      inj_v_i[s] = 1'b0;
   endtask

   task automatic send_random(input int s);
      for (int i = 0; i < n_rand; i++)
         inject(s, make_flit(e_msg_data, rnd_dst[s][i], s, rnd_pay[s][i]));
      release_inject(s);
   endtask

   task automatic send_to(input int s, input int d, input int cnt);
      for (int i = 0; i < cnt; i++)
         inject(s, make_flit(e_msg_data, d, s, 24'(s * 4096 + d * 256 + i)));
      release_inject(s);
   endtask

   task automatic cfg_write(input int k, input logic [3:0] addr, input logic [15:0] data);
      @(negedge clk_i);
      cfg_w_v_i[k]  = 1'b1;
      cfg_addr_i[k] = addr;
      cfg_data_i[k] = data;
      @(posedge clk_i);
      if (addr == e_cfg_ctrl)
         en_model[k] <= data[0];
      else if (addr == e_cfg_tag)
         tag_model[k] <= data;
      @(negedge clk_i);
      cfg_w_v_i[k] = 1'b0;
   endtask

   task automatic wait_drain();
      int n;
      n = 0;
      while (queued_total() != 0 && n < drain_limit)
      begin
         @(posedge clk_i);
         n++;
      end
      if (queued_total() != 0)
      begin
         err_other++;
         $display("Timeout: %0d flits were never delivered", queued_total());
      end
   endtask

   // Flits wait at tile k but none may leave during the window
   task automatic check_stall(input int k, input int src);
      int n;
      n = 0;
      while (!ej_v_o[k] && n < wait_limit)
      begin
         @(posedge clk_i);
         n++;
      end
      if (!ej_v_o[k])
      begin
         err_other++;
         $display("Timeout: no flit arrived at stalled tile %0d", k);
      end
      repeat (20) @(posedge clk_i);
      stall_valid: assert (ej_v_o[k])
      else
      begin
         err_other++;
         $display("Tile %0d dropped its held flit while its ejection was blocked", k);
      end
      stall_flit: assert (ej_flit_o[k] == sb_q[src][k][0])
      else
      begin
         err_mismatch++;
         $display("Mismatch ej_flit_o[%0d]: got %h, expected %h", k,
                  ej_flit_o[k], sb_q[src][k][0]);
      end
   endtask

   always @(posedge clk_i)
   begin : monitor
      tm_flit_s              got;
      logic [`TM_FLIT_W-1:0] want;
      if (!rst_i)
      begin
         for (int k = 0; k < n_tiles; k++)
         begin
            got = ej_flit_o[k];
            if (ej_v_o[k] && ej_ready_i[k] && en_model[k])
            begin
               if (sb_q[got.src][k].size() == 0)
               begin
                  err_other++;
                  $display("Unexpected flit %h ejected at tile %0d", got, k);
               end
               else
               begin
                  want = sb_q[got.src][k].pop_front();
                  checked++;
                  flit_order: assert (got == want)
                  else
                  begin
                     err_mismatch++;
                     $display("Mismatch ej_flit_o[%0d]: got %h, expected %h", k, got, want);
                  end
               end
            end
         end
      end
   end

   reset_idle: assert property (@(posedge clk_i) $fell(rst_i) |-> ej_v_o == '0)
   else
   begin
      err_other++;
      $display("Ejection valid was high right after reset");
   end

   for (genvar k = 0; k < n_tiles; k++)
   begin : g_chk
      held_stable: assert property (@(posedge clk_i) disable iff (rst_i)
         ej_v_o[k] && !(ej_ready_i[k] && en_model[k]) |=> ej_v_o[k] && $stable(ej_flit_o[k]))
      else
      begin
         err_other++;
         $display("Tile %0d changed or dropped a stalled flit", k);
      end

      no_cfg_eject: assert property (@(posedge clk_i) disable iff (rst_i)
         ej_v_o[k] |-> ej_flit_o[k][`TM_FLIT_W-1] == e_msg_data)
      else
      begin
         err_other++;
         $display("Tile %0d ejected a config flit", k);
      end

      dst_match: assert property (@(posedge clk_i) disable iff (rst_i)
         ej_v_o[k] |-> ej_flit_o[k][30:29] == 2'(k))
      else
      begin
         err_mismatch++;
         $display("Mismatch ej_flit_o[%0d] dst: got %h, expected %h", k,
                  $sampled(ej_flit_o[k][30:29]), 2'(k));
      end

      tag_match: assert property (@(posedge clk_i) disable iff (rst_i)
         ej_v_o[k] |-> ej_tag_o[k] == tag_model[k])
      else
      begin
         err_mismatch++;
         $display("Mismatch ej_tag_o[%0d]: got %h, expected %h", k,
                  $sampled(ej_tag_o[k]), $sampled(tag_model[k]));
      end
   end

   initial
   begin
      int n;
      tm_flit_s cf;
      rst_i      = 1'b1;
      inj_v_i    = '0;
      inj_flit_i = '0;
      ej_ready_i = '1;
      cfg_w_v_i  = '0;
      cfg_addr_i = '0;
      cfg_data_i = '0;
      en_model   = '1;
      tag_model  = '0;
      for (int s = 0; s < n_tiles; s++)
         for (int i = 0; i < n_rand; i++)
         begin
            rnd_dst[s][i] = 2'($random(seed));
            rnd_pay[s][i] = 24'($random(seed));
         end
      repeat (4) @(posedge clk_i);
      @(negedge clk_i);
      rst_i = 1'b0;

      n = 0;
      @(posedge clk_i);
      while (!(&inj_ready_o) && n < wait_limit)
      begin
         @(posedge clk_i);
         n++;
      end
      if (!(&inj_ready_o))
      begin
         err_other++;
         $display("Timeout: inj_ready_o did not rise after reset");
      end

      for (int k = 0; k < n_tiles; k++)
         cfg_write(k, e_cfg_tag, 16'($random(seed)));

      fork
         send_random(0);
         send_random(1);
         send_random(2);
         send_random(3);
      join
      wait_drain();

      // Tag written over the network from tile 0 to tile 3
      cf                     = make_flit(e_msg_cfg, 3, 0, 24'h0);
      cf.payload.cfg.addr    = e_cfg_tag;
      cf.payload.cfg.data    = 16'h5ac3;
      inject(0, cf);
      tag_model[3] <= 16'h5ac3;
      release_inject(0);
      send_to(0, 3, 2);
      wait_drain();

      cfg_write(2, e_cfg_ctrl, 16'h0000);
      send_to(0, 2, 3);
      check_stall(2, 0);
      cfg_write(2, e_cfg_ctrl, 16'h0001);
      wait_drain();

      @(negedge clk_i);
      ej_ready_i[1] = 1'b0;
      send_to(3, 1, 3);
      check_stall(1, 3);
      @(negedge clk_i);
      ej_ready_i[1] = 1'b1;
      wait_drain();

      fork
         send_to(0, 1, 6);
         send_to(1, 1, 6);
         send_to(2, 1, 6);
         send_to(3, 1, 6);
      join
      wait_drain();

      repeat (5) @(posedge clk_i);
      $display("Errors: %0d mismatches, %0d other failures, %0d flits checked",
               err_mismatch, err_other, checked);
      if (err_mismatch == 0 && err_other == 0 && checked > 0)
         $display("PASS: all tests");
      else
         $display("FAIL: see errors above");
      $finish;
   end

endmodule

//--- verilog.f
+incdir+include
rtl/tm_noc_pkg.sv
rtl/tm_tile_pkg.sv
rtl/tm_cfg_if.sv
rtl/tm_link_repeater.sv
rtl/tm_tile_cfg.sv
rtl/tm_tile_router.sv
rtl/tm_tile.sv
rtl/tm_tile_mesh.sv
tb/tm_tile_mesh_tb.sv
